// ==== arch_pkg.sv ====
`default_nettype none

package arch_pkg;

// -------------------------------------------------------------------------
// Words and status
// -------------------------------------------------------------------------

typedef logic [31:0] word_t;
typedef logic [31:0] cpsr_t;
typedef logic [4:0]  mode_t;

// CPSR bit positions.
localparam int unsigned CPSR_I = 7;
localparam int unsigned CPSR_F = 6;
localparam int unsigned CPSR_T = 5;

// Mode field codes.
localparam mode_t MODE_USR = 5'h10;
localparam mode_t MODE_FIQ = 5'h11;
localparam mode_t MODE_IRQ = 5'h12;
localparam mode_t MODE_SVC = 5'h13;
localparam mode_t MODE_ABT = 5'h17;
localparam mode_t MODE_UND = 5'h1b;

// Supervisor mode, IRQ and FIQ masked.
localparam cpsr_t CPSR_INIT = cpsr_t'((32'd1 << CPSR_I) | (32'd1 << CPSR_F) | MODE_SVC);

// -------------------------------------------------------------------------
// Exception vectors
// -------------------------------------------------------------------------

localparam word_t RESET_VECTOR = 32'h0000_0000;
localparam word_t UND_VECTOR   = 32'h0000_0004;
localparam word_t SWI_VECTOR   = 32'h0000_0008;
localparam word_t PABT_VECTOR  = 32'h0000_000c;
localparam word_t DABT_VECTOR  = 32'h0000_0010;
localparam word_t IRQ_VECTOR   = 32'h0000_0018;
localparam word_t FIQ_VECTOR   = 32'h0000_001c;

// Fetch step and the architectural PC index.
localparam word_t       PC_STEP = 32'd4;
localparam int unsigned ARCH_PC = 15;

endpackage

`default_nettype wire

// ==== wb_pkg.sv ====
`default_nettype none

package wb_pkg;

// -------------------------------------------------------------------------
// Physical register map
// -------------------------------------------------------------------------

localparam int unsigned PHY_REGS = 40;

typedef logic [$clog2(PHY_REGS)-1:0] phy_idx_t;

// 0 to 15 are the user registers, 16 to 22 hold FIQ R8 to R14.
// Each other mode banks R13 and R14 as a pair above that.
localparam phy_idx_t PHY_FIQ_R14  = 6'd22;
localparam phy_idx_t PHY_IRQ_R14  = 6'd24;
localparam phy_idx_t PHY_SVC_R14  = 6'd26;
localparam phy_idx_t PHY_ABT_R14  = 6'd28;
localparam phy_idx_t PHY_UND_R14  = 6'd30;

localparam phy_idx_t PHY_FIQ_SPSR = 6'd31;
localparam phy_idx_t PHY_IRQ_SPSR = 6'd32;
localparam phy_idx_t PHY_SVC_SPSR = 6'd33;
localparam phy_idx_t PHY_ABT_SPSR = 6'd34;
localparam phy_idx_t PHY_UND_SPSR = 6'd35;

// Writes here are dropped; reads give zero.
localparam phy_idx_t PHY_RAZ      = 6'd39;

// -------------------------------------------------------------------------
// Stage structs
// -------------------------------------------------------------------------

typedef struct packed {
        logic dabt;
        logic fiq;
        logic irq;
        logic iabt;
        logic swi;
        logic und;
} exc_t;

typedef struct packed {
        logic            valid;
        logic            mem_load;
        phy_idx_t        wr_index;
        arch_pkg::word_t wr_data;
        phy_idx_t        wr_index_1;
        arch_pkg::word_t wr_data_1;
        arch_pkg::cpsr_t flags;
} wb_req_t;

typedef struct packed {
        logic            valid;
        arch_pkg::word_t target;
} redirect_t;

typedef struct packed {
        logic            wen;
        phy_idx_t        wa1;
        arch_pkg::word_t wd1;
        phy_idx_t        wa2;
        arch_pkg::word_t wd2;
} rf_write_t;

typedef struct packed {
        logic            stb;
        arch_pkg::word_t pc;
} fetch_t;

typedef enum logic {
        ST_RUN,
        ST_SHELVED
} shelve_state_t;

endpackage

`default_nettype wire

// ==== wb_exception_ctrl.sv ====
`timescale 1ns/100ps
`default_nettype none

module wb_exception_ctrl
(
        input  wire                    i_clk,
        input  wire                    i_reset,
        input  wire wb_pkg::exc_t      i_exc,
        input  wire wb_pkg::wb_req_t   i_wb,
        input  wire arch_pkg::word_t   i_return_pc,
        input  wire                    i_clear_from_alu,
        input  wire arch_pkg::word_t   i_pc_from_alu,
        input  wire                    i_clear_from_decode,
        input  wire arch_pkg::word_t   i_pc_from_decode,
        output wb_pkg::rf_write_t      o_rf_write,
        output wb_pkg::redirect_t      o_redirect,
        output arch_pkg::cpsr_t        o_cpsr,
        output logic                   o_clear_from_writeback
);

import arch_pkg::*;
import wb_pkg::*;

cpsr_t    cpsr_ff;
cpsr_t    cpsr_nxt;
logic     exc_any;
logic     exc_fiq;
word_t    exc_link;
mode_t    exc_mode;
phy_idx_t exc_r14;
phy_idx_t exc_spsr;
word_t    exc_vector;
logic     pc_load;

assign pc_load = i_wb.valid && i_wb.mem_load && (i_wb.wr_index_1 == phy_idx_t'(ARCH_PC));
assign o_cpsr  = cpsr_ff;

// -------------------------------------------------------------------------
// Exception priority
// -------------------------------------------------------------------------

always_comb
begin
        exc_any    = 1'b1;
        exc_fiq    = 1'b0;
        exc_link   = i_wb.wr_data;
        exc_mode   = MODE_UND;
        exc_r14    = PHY_UND_R14;
        exc_spsr   = PHY_UND_SPSR;
        exc_vector = UND_VECTOR;

        if (i_exc.dabt)
        begin
                // Link is the buffered PC+8 of the aborted access.
                exc_link   = i_return_pc;
                exc_mode   = MODE_ABT;
                exc_r14    = PHY_ABT_R14;
                exc_spsr   = PHY_ABT_SPSR;
                exc_vector = DABT_VECTOR;
        end
        else if (i_exc.fiq)
        begin
                exc_fiq    = 1'b1;
                exc_mode   = MODE_FIQ;
                exc_r14    = PHY_FIQ_R14;
                exc_spsr   = PHY_FIQ_SPSR;
                exc_vector = FIQ_VECTOR;
        end
        else if (i_exc.irq)
        begin
                exc_mode   = MODE_IRQ;
                exc_r14    = PHY_IRQ_R14;
                exc_spsr   = PHY_IRQ_SPSR;
                exc_vector = IRQ_VECTOR;
        end
        else if (i_exc.iabt)
        begin
                exc_mode   = MODE_ABT;
                exc_r14    = PHY_ABT_R14;
                exc_spsr   = PHY_ABT_SPSR;
                exc_vector = PABT_VECTOR;
        end
        else if (i_exc.swi)
        begin
                exc_mode   = MODE_SVC;
                exc_r14    = PHY_SVC_R14;
                exc_spsr   = PHY_SVC_SPSR;
                exc_vector = SWI_VECTOR;
        end
        else if (!i_exc.und)
        begin
                // Defaults above describe UND.
                exc_any = 1'b0;
        end
end

// -------------------------------------------------------------------------
// Register writes, CPSR and next PC request
// -------------------------------------------------------------------------

always_comb
begin
        o_rf_write             = '{wen: 1'b0, wa1: PHY_RAZ, wd1: '0, wa2: PHY_RAZ, wd2: '0};
        o_redirect             = '0;
        o_clear_from_writeback = 1'b0;
        cpsr_nxt               = cpsr_ff;

        if (exc_any)
        begin
                // Banked link and saved status.
                o_rf_write.wen              = 1'b1;
                o_rf_write.wa1              = exc_r14;
                o_rf_write.wd1              = exc_link;
                o_rf_write.wa2              = exc_spsr;
                o_rf_write.wd2              = cpsr_ff;
                cpsr_nxt[$bits(mode_t)-1:0] = exc_mode;
                cpsr_nxt[CPSR_I]            = 1'b1;
                cpsr_nxt[CPSR_F]            = cpsr_ff[CPSR_F] | exc_fiq;
        end
        else if (i_wb.valid)
        begin
                o_rf_write.wen = 1'b1;
                o_rf_write.wa1 = i_wb.wr_index;
                o_rf_write.wd1 = i_wb.wr_data;
                o_rf_write.wa2 = i_wb.mem_load ? i_wb.wr_index_1 : PHY_RAZ;
                o_rf_write.wd2 = i_wb.wr_data_1;
                cpsr_nxt       = i_wb.flags;
        end

        if (exc_any)
        begin
                o_redirect             = '{valid: 1'b1, target: exc_vector};
                o_clear_from_writeback = 1'b1;
        end
        else if (pc_load)
        begin
                o_redirect             = '{valid: 1'b1, target: {i_wb.wr_data_1[31:1], 1'b0}};
                o_clear_from_writeback = 1'b1;
        end
        else if (i_clear_from_alu)
        begin
                o_redirect = '{valid: 1'b1, target: i_pc_from_alu};
        end
        else if (i_clear_from_decode)
        begin
                o_redirect = '{valid: 1'b1, target: i_pc_from_decode};
        end
end

always_ff @(posedge i_clk)
begin
        if (i_reset)
        begin
                cpsr_ff <= CPSR_INIT;
        end
        else
        begin
                cpsr_ff <= cpsr_nxt;
        end
end

endmodule

`default_nettype wire

// ==== wb_redirect_fsm.sv ====
`timescale 1ns/100ps
`default_nettype none

module wb_redirect_fsm
(
        input  wire                    i_clk,
        input  wire                    i_reset,
        input  wire wb_pkg::redirect_t i_redirect,
        input  wire                    i_code_stall,
        output wb_pkg::redirect_t      o_load,
        output logic                   o_hold
);

import arch_pkg::*;
import wb_pkg::*;

shelve_state_t state_ff;
shelve_state_t state_nxt;
word_t         shelf_ff;
word_t         shelf_nxt;
word_t         shelf_sel;

// The fetch side freezes for every stall.
assign o_hold = i_code_stall;

// A newer redirect replaces the shelved target.
assign shelf_sel = i_redirect.valid ? i_redirect.target : shelf_ff;

always_comb
begin
        state_nxt = state_ff;
        shelf_nxt = shelf_ff;
        o_load    = '0;

        case (state_ff)
        ST_RUN:
        begin
                if (i_redirect.valid && i_code_stall)
                begin
                        shelf_nxt = i_redirect.target;
                        state_nxt = ST_SHELVED;
                end
                else
                begin
                        o_load = i_redirect;
                end
        end
        ST_SHELVED:
        begin
                if (i_code_stall)
                begin
                        shelf_nxt = shelf_sel;
                end
                else
                begin
                        // Stall over. Release the target.
                        o_load    = '{valid: 1'b1, target: shelf_sel};
                        state_nxt = ST_RUN;
                end
        end
        endcase
end

always_ff @(posedge i_clk)
begin
        if (i_reset)
        begin
                state_ff <= ST_RUN;
        end
        else
        begin
                state_ff <= state_nxt;
        end
end

always_ff @(posedge i_clk)
begin
        shelf_ff <= shelf_nxt;
end

endmodule

`default_nettype wire

// ==== wb_pc_counter.sv ====
`timescale 1ns/100ps
`default_nettype none

module wb_pc_counter
(
        input  wire                    i_clk,
        input  wire                    i_reset,
        input  wire wb_pkg::redirect_t i_load,
        input  wire                    i_hold,
        output arch_pkg::word_t        o_pc_nxt,
        output wb_pkg::fetch_t         o_fetch
);

import arch_pkg::*;
import wb_pkg::*;

word_t        pc_ff;
word_t        pc_nxt;
fetch_t [2:0] del_ff;
fetch_t [2:0] del_nxt;
logic         hold_ff;

assign o_pc_nxt = pc_ff;
assign o_fetch  = del_ff[2];

always_comb
begin
        pc_nxt  = pc_ff;
        del_nxt = del_ff;

        if (i_load.valid)
        begin
                pc_nxt = i_load.target;

                if (hold_ff)
                begin
                        // Shelved target released. Flush the delay line.
                        del_nxt = '0;
                end
                else
                begin
                        // Direct redirect. Older PCs move on, strobes dropped.
                        del_nxt[0] = '{stb: 1'b0, pc: pc_ff};
                        del_nxt[1] = '{stb: 1'b0, pc: del_ff[0].pc};
                        del_nxt[2] = '{stb: 1'b0, pc: del_ff[1].pc};
                end
        end
        else if (!i_hold)
        begin
                pc_nxt     = pc_ff + PC_STEP;
                // Each PC that enters the line is a fetch.
                del_nxt[2] = del_ff[1];
                del_nxt[1] = del_ff[0];
                del_nxt[0] = '{stb: 1'b1, pc: pc_ff};
        end
end

always_ff @(posedge i_clk)
begin
        if (i_reset)
        begin
                pc_ff   <= RESET_VECTOR;
                del_ff  <= '0;
                hold_ff <= 1'b0;
        end
        else
        begin
                pc_ff   <= pc_nxt;
                del_ff  <= del_nxt;
                hold_ff <= i_hold;
        end
end

endmodule

`default_nettype wire

// ==== wb_register_file.sv ====
`timescale 1ns/100ps
`default_nettype none

module wb_register_file
(
        input  wire                    i_clk,
        input  wire wb_pkg::rf_write_t i_write,
        input  wire wb_pkg::phy_idx_t  i_rd_index_0,
        input  wire wb_pkg::phy_idx_t  i_rd_index_1,
        output arch_pkg::word_t        o_rd_data_0,
        output arch_pkg::word_t        o_rd_data_1
);

import arch_pkg::*;
import wb_pkg::*;

word_t mem [PHY_REGS];

// -------------------------------------------------------------------------
// Write ports
// -------------------------------------------------------------------------

always_ff @(posedge i_clk)
begin
        if (i_write.wen)
        begin
                mem[i_write.wa1] <= i_write.wd1;
                // Port 2 comes last and wins on a shared index.
                mem[i_write.wa2] <= i_write.wd2;
        end
end

// -------------------------------------------------------------------------
// Read ports
// -------------------------------------------------------------------------

assign o_rd_data_0 = (i_rd_index_0 == PHY_RAZ) ? '0 : mem[i_rd_index_0];
assign o_rd_data_1 = (i_rd_index_1 == PHY_RAZ) ? '0 : mem[i_rd_index_1];

endmodule

`default_nettype wire

// ==== wb_stage.sv ====
`timescale 1ns/100ps
`default_nettype none

module wb_stage
(
        input  wire                    i_clk,
        input  wire                    i_reset,
        input  wire wb_pkg::exc_t      i_exc,
        input  wire wb_pkg::wb_req_t   i_wb,
        input  wire arch_pkg::word_t   i_return_pc,
        input  wire                    i_clear_from_alu,
        input  wire arch_pkg::word_t   i_pc_from_alu,
        input  wire                    i_clear_from_decode,
        input  wire arch_pkg::word_t   i_pc_from_decode,
        input  wire                    i_code_stall,
        input  wire wb_pkg::phy_idx_t  i_rd_index_0,
        input  wire wb_pkg::phy_idx_t  i_rd_index_1,
        output arch_pkg::word_t        o_rd_data_0,
        output arch_pkg::word_t        o_rd_data_1,
        output arch_pkg::word_t        o_pc_nxt,
        output wb_pkg::fetch_t         o_fetch,
        output arch_pkg::cpsr_t        o_cpsr,
        output logic                   o_clear_from_writeback
);

import wb_pkg::*;

rf_write_t rf_write;
redirect_t redirect;
redirect_t load;
logic      hold;

// -------------------------------------------------------------------------
// Writeback decode and PC request
// -------------------------------------------------------------------------

wb_exception_ctrl u_exception_ctrl
(
        .i_clk                  (i_clk),
        .i_reset                (i_reset),
        .i_exc                  (i_exc),
        .i_wb                   (i_wb),
        .i_return_pc            (i_return_pc),
        .i_clear_from_alu       (i_clear_from_alu),
        .i_pc_from_alu          (i_pc_from_alu),
        .i_clear_from_decode    (i_clear_from_decode),
        .i_pc_from_decode       (i_pc_from_decode),
        .o_rf_write             (rf_write),
        .o_redirect             (redirect),
        .o_cpsr                 (o_cpsr),
        .o_clear_from_writeback (o_clear_from_writeback)
);

wb_register_file u_register_file
(
        .i_clk        (i_clk),
        .i_write      (rf_write),
        .i_rd_index_0 (i_rd_index_0),
        .i_rd_index_1 (i_rd_index_1),
        .o_rd_data_0  (o_rd_data_0),
        .o_rd_data_1  (o_rd_data_1)
);

// -------------------------------------------------------------------------
// Fetch PC path
// -------------------------------------------------------------------------

wb_redirect_fsm u_redirect_fsm
(
        .i_clk        (i_clk),
        .i_reset      (i_reset),
        .i_redirect   (redirect),
        .i_code_stall (i_code_stall),
        .o_load       (load),
        .o_hold       (hold)
);

wb_pc_counter u_pc_counter
(
        .i_clk    (i_clk),
        .i_reset  (i_reset),
        .i_load   (load),
        .i_hold   (hold),
        .o_pc_nxt (o_pc_nxt),
        .o_fetch  (o_fetch)
);

endmodule

`default_nettype wire

// ==== wb_stage_chk.sv ====
`timescale 1ns/100ps
`default_nettype none

module wb_stage_chk
(
        input  wire                   i_clk,
        input  wire                   i_reset,
        input  wire wb_pkg::exc_t     i_exc,
        input  wire wb_pkg::wb_req_t  i_wb,
        input  wire                   i_clear_from_alu,
        input  wire arch_pkg::word_t  i_pc_from_alu,
        input  wire                   i_clear_from_decode,
        input  wire arch_pkg::word_t  i_pc_from_decode,
        input  wire                   i_code_stall,
        input  wire arch_pkg::word_t  i_pc_nxt,
        input  wire wb_pkg::fetch_t   i_fetch,
        input  wire arch_pkg::cpsr_t  i_cpsr,
        input  wire                   i_clear_from_writeback
);

import arch_pkg::*;
import wb_pkg::*;

int unsigned fail_count = 0;
logic        exc_any;
word_t       exp_vector;
logic        pc_load;
logic        redir_req;
word_t       redir_target;
word_t       release_target;
logic        shelf_valid;
word_t       shelf_target;
logic        quiet;
logic        quiet_q1;
logic        quiet_q2;

// -------------------------------------------------------------------------
// Expected next PC from the event priority
// -------------------------------------------------------------------------

assign exc_any = (i_exc != '0);
assign pc_load = i_wb.valid && i_wb.mem_load && (i_wb.wr_index_1 == phy_idx_t'(ARCH_PC));

always_comb
begin
        redir_req = 1'b1;
        if (i_exc.dabt)
                exp_vector = DABT_VECTOR;
        else if (i_exc.fiq)
                exp_vector = FIQ_VECTOR;
        else if (i_exc.irq)
                exp_vector = IRQ_VECTOR;
        else if (i_exc.iabt)
                exp_vector = PABT_VECTOR;
        else if (i_exc.swi)
                exp_vector = SWI_VECTOR;
        else
                exp_vector = UND_VECTOR;

        if (exc_any)
                redir_target = exp_vector;
        else if (pc_load)
                redir_target = i_wb.wr_data_1 & ~32'd1;
        else if (i_clear_from_alu)
                redir_target = i_pc_from_alu;
        else if (i_clear_from_decode)
                redir_target = i_pc_from_decode;
        else
        begin
                redir_req    = 1'b0;
                redir_target = '0;
        end
end

// A newer redirect replaces the shelved one.
assign release_target = redir_req ? redir_target : shelf_target;
assign quiet          = !i_code_stall && !redir_req && !shelf_valid;

// Shadow of the shelf and a short history of quiet cycles.
always_ff @(posedge i_clk)
begin
        if (i_reset)
        begin
                shelf_valid <= 1'b0;
                quiet_q1    <= 1'b0;
                quiet_q2    <= 1'b0;
        end
        else
        begin
                quiet_q1 <= quiet;
                quiet_q2 <= quiet_q1;
                if (i_code_stall && redir_req)
                begin
                        shelf_valid  <= 1'b1;
                        shelf_target <= redir_target;
                end
                else if (!i_code_stall)
                begin
                        shelf_valid <= 1'b0;
                end
        end
end

// -------------------------------------------------------------------------
// Properties
// -------------------------------------------------------------------------

a_reset: assert property (@(posedge i_clk)
        i_reset |=> (i_pc_nxt == RESET_VECTOR && !i_fetch.stb && i_cpsr == CPSR_INIT))
else
begin
        fail_count = fail_count + 1;
        $error("Reset state wrong, pc %h cpsr %h", i_pc_nxt, i_cpsr);
end

a_step: assert property (@(posedge i_clk) disable iff (i_reset)
        quiet |=> i_pc_nxt == $past(i_pc_nxt) + PC_STEP)
else
begin
        fail_count = fail_count + 1;
        $error("PC did not advance by one step, pc %h", i_pc_nxt);
end

// Three quiet cycles push the PC out through the delay line.
a_fetch: assert property (@(posedge i_clk) disable iff (i_reset)
        (quiet && quiet_q1 && quiet_q2) |=> (i_fetch.stb && i_fetch.pc == $past(i_pc_nxt, 3)))
else
begin
        fail_count = fail_count + 1;
        $error("Fetch strobe or PC wrong, fetch pc %h", i_fetch.pc);
end

a_clear: assert property (@(posedge i_clk) disable iff (i_reset)
        i_clear_from_writeback == (exc_any || pc_load))
else
begin
        fail_count = fail_count + 1;
        $error("Clear from writeback is %b", i_clear_from_writeback);
end

a_redirect: assert property (@(posedge i_clk) disable iff (i_reset)
        (redir_req && !i_code_stall) |=> (i_pc_nxt == $past(redir_target) && !i_fetch.stb))
else
begin
        fail_count = fail_count + 1;
        $error("Redirect not taken, pc %h", i_pc_nxt);
end

a_stall: assert property (@(posedge i_clk) disable iff (i_reset)
        i_code_stall |=> ($stable(i_pc_nxt) && $stable(i_fetch)))
else
begin
        fail_count = fail_count + 1;
        $error("Fetch side moved during a stall, pc %h", i_pc_nxt);
end

a_release: assert property (@(posedge i_clk) disable iff (i_reset)
        (shelf_valid && !i_code_stall) |=> (i_pc_nxt == $past(release_target) && !i_fetch.stb))
else
begin
        fail_count = fail_count + 1;
        $error("Shelved target not released, pc %h", i_pc_nxt);
end

endmodule

bind wb_stage wb_stage_chk u_chk
(
        .i_clk                  (i_clk),
        .i_reset                (i_reset),
        .i_exc                  (i_exc),
        .i_wb                   (i_wb),
        .i_clear_from_alu       (i_clear_from_alu),
        .i_pc_from_alu          (i_pc_from_alu),
        .i_clear_from_decode    (i_clear_from_decode),
        .i_pc_from_decode       (i_pc_from_decode),
        .i_code_stall           (i_code_stall),
        .i_pc_nxt               (o_pc_nxt),
        .i_fetch                (o_fetch),
        .i_cpsr                 (o_cpsr),
        .i_clear_from_writeback (o_clear_from_writeback)
);

`default_nettype wire

// ==== tb_wb_stage.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_wb_stage;

import arch_pkg::*;
import wb_pkg::*;

logic     i_clk;
logic     i_reset;
exc_t     i_exc;
wb_req_t  i_wb;
word_t    i_return_pc;
logic     i_clear_from_alu;
word_t    i_pc_from_alu;
logic     i_clear_from_decode;
word_t    i_pc_from_decode;
logic     i_code_stall;
phy_idx_t i_rd_index_0;
phy_idx_t i_rd_index_1;
word_t    o_rd_data_0;
word_t    o_rd_data_1;
word_t    o_pc_nxt;
fetch_t   o_fetch;
cpsr_t    o_cpsr;
logic     o_clear_from_writeback;

// Expected register file and status word.
word_t    exp_regs [PHY_REGS];
cpsr_t    exp_cpsr;

wb_stage u_dut
(
        .i_clk                  (i_clk),
        .i_reset                (i_reset),
        .i_exc                  (i_exc),
        .i_wb                   (i_wb),
        .i_return_pc            (i_return_pc),
        .i_clear_from_alu       (i_clear_from_alu),
        .i_pc_from_alu          (i_pc_from_alu),
        .i_clear_from_decode    (i_clear_from_decode),
        .i_pc_from_decode       (i_pc_from_decode),
        .i_code_stall           (i_code_stall),
        .i_rd_index_0           (i_rd_index_0),
        .i_rd_index_1           (i_rd_index_1),
        .o_rd_data_0            (o_rd_data_0),
        .o_rd_data_1            (o_rd_data_1),
        .o_pc_nxt               (o_pc_nxt),
        .o_fetch                (o_fetch),
        .o_cpsr                 (o_cpsr),
        .o_clear_from_writeback (o_clear_from_writeback)
);

always #20 i_clk = ~i_clk;

// -------------------------------------------------------------------------
// Helpers
// -------------------------------------------------------------------------

task automatic end_with_failure();
        $display("Checks failed");
        $fatal(1, "Run stopped at %0t.", $time);
endtask

task automatic check_word(input string name, input word_t exp, input word_t act);
        if (act !== exp)
        begin
                $display("** Error at %0t: %s expected %h, actual %h", $time, name, exp, act);
                end_with_failure();
        end
endtask

function automatic void model_write(input phy_idx_t idx, input word_t data);
        if (idx != PHY_RAZ)
                exp_regs[idx] = data;
endfunction

task automatic check_regs(input phy_idx_t a, input phy_idx_t b);
        i_rd_index_0 = a;
        i_rd_index_1 = b;
        @(negedge i_clk);
        check_word($sformatf("o_rd_data_0 (reg %0d)", a), exp_regs[a], o_rd_data_0);
        check_word($sformatf("o_rd_data_1 (reg %0d)", b), exp_regs[b], o_rd_data_1);
endtask

task automatic wait_fetch_strobe(input int limit);
        int n;
        n = 0;
        while (!o_fetch.stb && n < limit)
        begin
                @(negedge i_clk);
                n++;
        end
        if (!o_fetch.stb)
        begin
                $display("Timed out waiting for o_fetch.stb.");
                end_with_failure();
        end
endtask

task automatic write_back(input phy_idx_t a, input phy_idx_t b, input logic mem_load);
        wb_req_t req;
        req            = '0;
        req.valid      = 1'b1;
        req.mem_load   = mem_load;
        req.wr_index   = a;
        req.wr_data    = $urandom;
        req.wr_index_1 = b;
        req.wr_data_1  = $urandom;
        // Random NZCV and masks, user mode.
        req.flags      = {4'($urandom), 20'd0, 2'($urandom), 1'b0, MODE_USR};
        i_wb = req;
        @(negedge i_clk);
        i_wb = '0;
        model_write(a, req.wr_data);
        if (mem_load)
                model_write(b, req.wr_data_1);
        exp_cpsr = req.flags;
        check_word("o_cpsr", exp_cpsr, o_cpsr);
        check_regs(a, mem_load ? b : PHY_RAZ);
endtask

task automatic take_exception(input exc_t e, input phy_idx_t r14, input phy_idx_t spsr,
                              input mode_t mode, input logic fiq);
        word_t link;
        word_t ret;
        cpsr_t old;
        link        = $urandom;
        ret         = $urandom;
        old         = exp_cpsr;
        i_exc       = e;
        i_wb        = '0;
        i_wb.wr_data = link;
        i_return_pc = ret;
        @(negedge i_clk);
        i_exc = '0;
        i_wb  = '0;
        // Data abort links the buffered PC+8.
        model_write(r14, e.dabt ? ret : link);
        model_write(spsr, old);
        exp_cpsr[4:0]  = mode;
        exp_cpsr[CPSR_I] = 1'b1;
        if (fiq)
                exp_cpsr[CPSR_F] = 1'b1;
        check_word("o_cpsr", exp_cpsr, o_cpsr);
        check_regs(r14, spsr);
endtask

task automatic redirect_pulse(input logic from_alu, input word_t target);
        if (from_alu)
        begin
                i_clear_from_alu = 1'b1;
                i_pc_from_alu    = target;
        end
        else
        begin
                i_clear_from_decode = 1'b1;
                i_pc_from_decode    = target;
        end
        @(negedge i_clk);
        i_clear_from_alu    = 1'b0;
        i_clear_from_decode = 1'b0;
endtask

// Failed assertions in the checker end the run.
always @(negedge i_clk)
begin
        if (u_dut.u_chk.fail_count != 0)
        begin
                $display("An assertion in wb_stage_chk failed.");
                end_with_failure();
        end
end

// -------------------------------------------------------------------------
// Stimulus
// -------------------------------------------------------------------------

initial
begin
        int       i;
        phy_idx_t a;
        phy_idx_t b;
        i_clk               = 1'b0;
        i_reset             = 1'b1;
        i_exc               = '0;
        i_wb                = '0;
        i_return_pc         = '0;
        i_clear_from_alu    = 1'b0;
        i_pc_from_alu       = '0;
        i_clear_from_decode = 1'b0;
        i_pc_from_decode    = '0;
        i_code_stall        = 1'b0;
        i_rd_index_0        = '0;
        i_rd_index_1        = '0;
        exp_cpsr            = CPSR_INIT;
        exp_regs[PHY_RAZ]   = '0;
        void'($urandom(32'h39c9));

        repeat (16) @(negedge i_clk);
        i_reset = 1'b0;
        check_word("o_pc_nxt", RESET_VECTOR, o_pc_nxt);
        check_word("o_cpsr", CPSR_INIT, o_cpsr);
        wait_fetch_strobe(8);
        repeat (6) @(negedge i_clk);

        // Writebacks, one pair on the same index.
        for (i = 0; i < 6; i++)
        begin
                a = phy_idx_t'($urandom_range(0, 14));
                b = phy_idx_t'($urandom_range(0, 14));
                write_back(a, b, i[0]);
        end
        write_back(phy_idx_t'(3), phy_idx_t'(3), 1'b1);

        // Memory load to the PC.
        write_back(phy_idx_t'(4), phy_idx_t'(ARCH_PC), 1'b1);
        wait_fetch_strobe(8);

        // Order is dabt, fiq, irq, iabt, swi, und.
        take_exception(exc_t'(6'b001000), PHY_IRQ_R14, PHY_IRQ_SPSR, MODE_IRQ, 1'b0);
        take_exception(exc_t'(6'b010000), PHY_FIQ_R14, PHY_FIQ_SPSR, MODE_FIQ, 1'b1);
        take_exception(exc_t'(6'b101000), PHY_ABT_R14, PHY_ABT_SPSR, MODE_ABT, 1'b0);
        take_exception(exc_t'(6'b011000), PHY_FIQ_R14, PHY_FIQ_SPSR, MODE_FIQ, 1'b1);
        take_exception(exc_t'(6'b000111), PHY_ABT_R14, PHY_ABT_SPSR, MODE_ABT, 1'b0);
        take_exception(exc_t'(6'b000011), PHY_SVC_R14, PHY_SVC_SPSR, MODE_SVC, 1'b0);
        take_exception(exc_t'(6'b000001), PHY_UND_R14, PHY_UND_SPSR, MODE_UND, 1'b0);
        wait_fetch_strobe(8);

        // Direct redirects.
        redirect_pulse(1'b1, $urandom & ~32'd3);
        repeat (2) @(negedge i_clk);
        redirect_pulse(1'b0, $urandom & ~32'd3);
        wait_fetch_strobe(8);

        // Shelved redirect, then a newer one over it.
        i_code_stall = 1'b1;
        repeat (2) @(negedge i_clk);
        redirect_pulse(1'b1, 32'h0000_4000);
        repeat (3) @(negedge i_clk);
        redirect_pulse(1'b0, 32'h0000_8000);
        repeat (2) @(negedge i_clk);
        i_code_stall = 1'b0;
        // The strobe stays frozen until the first unstalled edge.
        @(negedge i_clk);
        wait_fetch_strobe(8);

        // Stall with nothing to shelve.
        i_code_stall = 1'b1;
        repeat (3) @(negedge i_clk);
        i_code_stall = 1'b0;
        @(negedge i_clk);
        wait_fetch_strobe(8);

        // Random mix of stalls and events.
        for (i = 0; i < 300; i++)
        begin
                i_code_stall        = ($urandom_range(0, 3) == 0);
                i_clear_from_alu    = ($urandom_range(0, 7) == 0);
                i_pc_from_alu       = $urandom;
                i_clear_from_decode = ($urandom_range(0, 7) == 0);
                i_pc_from_decode    = $urandom;
                i_exc               = ($urandom_range(0, 15) == 0) ? exc_t'(6'($urandom)) : '0;
                i_return_pc         = $urandom;
                i_wb                = '0;
                i_wb.valid          = ($urandom_range(0, 3) == 0);
                i_wb.mem_load       = 1'($urandom);
                i_wb.wr_index       = phy_idx_t'($urandom_range(0, 39));
                i_wb.wr_data        = $urandom;
                i_wb.wr_index_1     = ($urandom_range(0, 3) == 0) ? phy_idx_t'(ARCH_PC)
                                                                 : phy_idx_t'($urandom_range(0, 39));
                i_wb.wr_data_1      = $urandom;
                i_wb.flags          = $urandom;
                @(negedge i_clk);
        end
        i_code_stall        = 1'b0;
        i_clear_from_alu    = 1'b0;
        i_clear_from_decode = 1'b0;
        i_exc               = '0;
        i_wb                = '0;
        wait_fetch_strobe(8);
        repeat (2) @(negedge i_clk);

        if (u_dut.u_chk.fail_count != 0)
        begin
                $display("An assertion in wb_stage_chk failed.");
                end_with_failure();
        end
        else
        begin
                $display("All checks passed");
                $finish;
        end
end

endmodule

`default_nettype wire

// ==== files.f ====
arch_pkg.sv
wb_pkg.sv
wb_exception_ctrl.sv
wb_redirect_fsm.sv
wb_pc_counter.sv
wb_register_file.sv
wb_stage.sv
wb_stage_chk.sv
tb_wb_stage.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --assert --timing
TOP       ?= tb_wb_stage
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
SIM_ARGS  ?= +verilator+error+limit+100

SRCS := $(filter %.sv,$(shell cat files.f))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): files.f $(SRCS)
	$(VERILATOR) $(VFLAGS) -f files.f --top-module $(TOP) -Mdir $(OBJ_DIR)

run: $(BIN)
	-$(BIN) $(SIM_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "^All checks passed$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
